// File: mean_pkg.sv
// Samples are fixed at 16 bits; sums are sized for at most 2**7 samples, so deeper trees overflow
`default_nettype none

package mean_pkg;

    // One input sample, also the width of the mean
    localparam int DATA_W = 16;

    // Deepest adder tree the sum width is sized for
    localparam int MAX_LOG2_INPUTS = 7;

    // Full sum of 2**MAX_LOG2_INPUTS samples fits without carry loss
    localparam int SUM_W = DATA_W + MAX_LOG2_INPUTS;

    // Output buffer entries
    localparam int BUF_DEPTH = 2;

    // Unsigned sample or mean
    typedef logic [DATA_W-1:0] sample_t;

    // Partial sum at any tree level
    typedef logic [SUM_W-1:0] sum_t;

    // Buffer occupancy, 0 up to BUF_DEPTH
    typedef logic [$clog2(BUF_DEPTH+1)-1:0] count_t;

    // Buffer slot index
    typedef logic [$clog2(BUF_DEPTH)-1:0] ptr_t;

endpackage

`default_nettype wire

// File: pair_sum_level.sv
// LEVEL must be below LOG2_INPUTS; in_ready depends combinationally on out_ready
`default_nettype none

module pair_sum_level
    import mean_pkg::*;
#(
    parameter int LOG2_INPUTS = 7,
    parameter int LEVEL       = 0
) (
    input  logic                                  clk,
    input  logic                                  rst,

    // Upstream side
    input  logic                                  in_valid,
    output logic                                  in_ready,
    input  sum_t [2**(LOG2_INPUTS-LEVEL)-1:0]     in_sums,

    // Downstream side
    output logic                                  out_valid,
    input  logic                                  out_ready,
    output sum_t [2**(LOG2_INPUTS-LEVEL-1)-1:0]   out_sums
);

    // Sums produced by this level
    localparam int N_OUT = 2**(LOG2_INPUTS - LEVEL - 1);

    sum_t [N_OUT-1:0] pair_sums;
    logic             load;

    // Neighbouring pairs, even index plus the odd one after it
    always_comb begin
        for (int i = 0; i < N_OUT; i++) begin
            pair_sums[i] = in_sums[2*i] + in_sums[2*i+1];
        end
    end

    // Free slot, or the held result leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_sums  <= '0;
        end else begin
            if (load) begin
                out_sums  <= pair_sums;
                out_valid <= 1'b1;
            end else if (out_ready) begin
                // Result taken and nothing new arrived
                out_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: mean_output_buffer.sv
// Mean is the sum shifted by LOG2_INPUTS and truncated; in_ready only looks at the held count
`default_nettype none

module mean_output_buffer
    import mean_pkg::*;
#(
    parameter int LOG2_INPUTS = 7
) (
    input  logic    clk,
    input  logic    rst,

    // Final sum from the last tree level
    input  logic    in_valid,
    output logic    in_ready,
    input  sum_t    in_sum,

    // Mean towards the consumer
    output logic    out_valid,
    input  logic    out_ready,
    output sample_t mean
);

    sample_t entries [BUF_DEPTH];
    ptr_t    wr_ptr;
    ptr_t    rd_ptr;
    count_t  count;

    sum_t    shifted;
    sample_t scaled;
    logic    push;
    logic    pop;

    // Divide by the input count, remainder dropped
    assign shifted = in_sum >> LOG2_INPUTS;
    assign scaled  = shifted[DATA_W-1:0];

    assign in_ready  = (count != count_t'(BUF_DEPTH));
    assign out_valid = (count != '0);
    assign mean      = entries[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // Entry storage
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BUF_DEPTH; i++) begin
                entries[i] <= '0;
            end
        end else if (push) begin
            entries[wr_ptr] <= scaled;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_t'(wr_ptr + 1'b1);
            end
            if (pop) begin
                rd_ptr <= ptr_t'(rd_ptr + 1'b1);
            end
            case ({push, pop})
                2'b10:   count <= count_t'(count + 1'b1);
                2'b01:   count <= count_t'(count - 1'b1);
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: mean128.sv
// LOG2_INPUTS from 1 to 7; out_valid follows acceptance by LOG2_INPUTS cycles when unstalled
`default_nettype none

module mean128
    import mean_pkg::*;
#(
    parameter int LOG2_INPUTS = 7
) (
    input  logic                               clk,
    input  logic                               rst,

    // Sample set input
    input  logic                               in_valid,
    output logic                               in_ready,
    input  sample_t [2**LOG2_INPUTS-1:0]       samples,

    // Mean output
    output logic                               out_valid,
    input  logic                               out_ready,
    output sample_t                            mean
);

    localparam int N_IN = 2**LOG2_INPUTS;

    // Rows of the tree packed end to end from the samples to the total
    sum_t [2*N_IN-2:0]    tree_sums;
    logic [LOG2_INPUTS:0] level_valid;
    logic [LOG2_INPUTS:0] level_ready;

    // Zero extend each sample into the first row
    for (genvar i = 0; i < N_IN; i++) begin : g_widen
        assign tree_sums[i] = {{(SUM_W-DATA_W){1'b0}}, samples[i]};
    end

    assign level_valid[0] = in_valid;
    assign in_ready       = level_ready[0];

    for (genvar l = 0; l < LOG2_INPUTS; l++) begin : g_level
        localparam int N_L_IN   = 2**(LOG2_INPUTS - l);
        localparam int N_L_OUT  = N_L_IN / 2;
        // Row l starts where the larger rows before it end
        localparam int IN_BASE  = 2*N_IN - 2*N_L_IN;
        localparam int OUT_BASE = IN_BASE + N_L_IN;

        pair_sum_level #(
            .LOG2_INPUTS (LOG2_INPUTS),
            .LEVEL       (l)
        ) u_level (
            .clk       (clk),
            .rst       (rst),
            .in_valid  (level_valid[l]),
            .in_ready  (level_ready[l]),
            .in_sums   (tree_sums[IN_BASE+N_L_IN-1:IN_BASE]),
            .out_valid (level_valid[l+1]),
            .out_ready (level_ready[l+1]),
            .out_sums  (tree_sums[OUT_BASE+N_L_OUT-1:OUT_BASE])
        );
    end

    mean_output_buffer #(
        .LOG2_INPUTS (LOG2_INPUTS)
    ) u_buffer (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (level_valid[LOG2_INPUTS]),
        .in_ready  (level_ready[LOG2_INPUTS]),
        .in_sum    (tree_sums[2*N_IN-2]),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .mean      (mean)
    );

endmodule

`default_nettype wire

// File: tb_mean128.sv
// Runs from the project root to find mean_tests.txt; default depth of 128 samples only
`default_nettype none

module tb_mean128
    import mean_pkg::*;
;
    localparam int LOG2_INPUTS  = 7;
    localparam int N_IN         = 2**LOG2_INPUTS;
    localparam int TIMEOUT      = 200;
    localparam int RESET_CYCLES = 16;
    localparam int STREAM_SETS  = 20;
    localparam int BP_SETS      = 40;

    logic                 clk;
    logic                 rst;
    logic                 in_valid;
    logic                 in_ready;
    sample_t [N_IN-1:0]   samples;
    logic                 out_valid;
    logic                 out_ready;
    sample_t              mean;

    sample_t exp_q[$];
    int      rx_cycles[$];
    int      cycle;
    int      stall_cycles;
    int      errors;
    int      pass_count;
    int      fail_count;
    logic    timed_out;
    logic    bp_active;

    mean128 #(
        .LOG2_INPUTS (LOG2_INPUTS)
    ) u_mean128 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .samples   (samples),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .mean      (mean)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Consumer ready, random only during the back-pressure phase
    initial begin
        out_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (bp_active) begin
                out_ready = ($urandom_range(0, 3) == 0);
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            errors++;
        end
    endtask

    // Output monitor, every transfer is compared in send order
    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("a mean of 0x%0h came out with no set outstanding", mean);
                errors++;
            end else begin
                check_value("mean", 32'(mean), 32'(exp_q.pop_front()));
            end
            rx_cycles.push_back(cycle);
        end
        if (!rst && !out_ready && !in_ready) begin
            stall_cycles++;
        end
        cycle++;
    end

    function automatic sample_t model_mean(input sample_t [N_IN-1:0] set);
        longint total;
        total = 0;
        for (int i = 0; i < N_IN; i++) begin
            total += set[i];
        end
        return sample_t'(total >> LOG2_INPUTS);
    endfunction

    task automatic fill_ramp(output sample_t [N_IN-1:0] set, input logic [31:0] base,
                             input logic [31:0] step);
        for (int i = 0; i < N_IN; i++) begin
            set[i] = sample_t'(base + 32'(i) * step);
        end
    endtask

    task automatic fill_random(output sample_t [N_IN-1:0] set);
        for (int i = 0; i < N_IN; i++) begin
            set[i] = sample_t'($urandom);
        end
    endtask

    // Returns on the edge where the set is accepted
    task automatic send_set(input sample_t [N_IN-1:0] set, input sample_t expected);
        int waited;
        waited = 0;
        @(negedge clk);
        in_valid = 1'b1;
        samples  = set;
        @(posedge clk);
        while (!in_ready && !timed_out) begin
            waited++;
            if (waited >= TIMEOUT) begin
                $display("timeout: in_ready never went high to take a sample set");
                timed_out = 1'b1;
                errors++;
            end else begin
                @(posedge clk);
            end
        end
        if (!timed_out) begin
            exp_q.push_back(expected);
        end
    endtask

    task automatic drop_valid();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && !timed_out) begin
            @(negedge clk);
            waited++;
            if (waited >= TIMEOUT && exp_q.size() != 0) begin
                $display("timeout: out_valid never brought the last %0d means", exp_q.size());
                timed_out = 1'b1;
                errors++;
            end
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic check_reset_state();
        int start;
        start = errors;
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(negedge clk);
            check_value("out_valid", 32'(out_valid), 0);
            check_value("in_ready", 32'(in_ready), 1);
        end
        rst = 1'b0;
        @(negedge clk);
        check_value("out_valid", 32'(out_valid), 0);
        check_value("in_ready", 32'(in_ready), 1);
        report_test("reset", start);
    endtask

    task automatic run_directed_vectors();
        int                 fd;
        int                 n;
        int                 count;
        int                 start;
        string              line;
        logic [31:0]        base;
        logic [31:0]        step;
        logic [31:0]        file_mean;
        sample_t [N_IN-1:0] set;
        start = errors;
        count = 0;
        fd = $fopen("mean_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open mean_tests.txt");
            errors++;
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                n = $sscanf(line, "%h %h %h", base, step, file_mean);
                if (line[0] != "#" && n == 3) begin
                    fill_ramp(set, base, step);
                    check_value("model mean", 32'(model_mean(set)), file_mean);
                    send_set(set, sample_t'(file_mean));
                    drop_valid();
                    wait_drain();
                    count++;
                end
            end
            $fclose(fd);
            if (count == 0) begin
                $display("mean_tests.txt held no test vectors");
                errors++;
            end
        end
        report_test("directed", start);
    endtask

    task automatic measure_latency();
        sample_t [N_IN-1:0] set;
        int                 start;
        start = errors;
        fill_random(set);
        send_set(set, model_mean(set));
        // Low after edges k to k+6, high after k+7
        for (int j = 0; j < LOG2_INPUTS; j++) begin
            @(negedge clk);
            if (j == 0) begin
                in_valid = 1'b0;
            end
            check_value("out_valid", 32'(out_valid), 0);
        end
        @(negedge clk);
        check_value("out_valid", 32'(out_valid), 1);
        wait_drain();
        report_test("latency", start);
    endtask

    task automatic stream_random_sets();
        sample_t [N_IN-1:0] set;
        int                 start;
        start = errors;
        rx_cycles.delete();
        for (int k = 0; k < STREAM_SETS; k++) begin
            fill_random(set);
            send_set(set, model_mean(set));
        end
        drop_valid();
        wait_drain();
        check_value("arrival count", 32'(rx_cycles.size()), STREAM_SETS);
        if (rx_cycles.size() == STREAM_SETS) begin
            check_value("arrival span", 32'(rx_cycles[STREAM_SETS-1] - rx_cycles[0]),
                        STREAM_SETS - 1);
        end
        report_test("streaming", start);
    endtask

    task automatic apply_back_pressure();
        sample_t [N_IN-1:0] set;
        int                 start;
        int                 stalls_before;
        start = errors;
        stalls_before = stall_cycles;
        @(posedge clk);
        bp_active = 1'b1;
        for (int k = 0; k < BP_SETS; k++) begin
            if ($urandom_range(0, 2) == 0) begin
                drop_valid();
            end
            fill_random(set);
            send_set(set, model_mean(set));
        end
        drop_valid();
        wait_drain();
        @(posedge clk);
        bp_active = 1'b0;
        if (stall_cycles == stalls_before) begin
            $display("in_ready never went low while out_ready was held low");
            errors++;
        end
        report_test("back-pressure", start);
    endtask

    initial begin
        void'($urandom(82));
        rst          = 1'b1;
        in_valid     = 1'b0;
        samples      = '0;
        bp_active    = 1'b0;
        timed_out    = 1'b0;
        errors       = 0;
        pass_count   = 0;
        fail_count   = 0;
        cycle        = 0;
        stall_cycles = 0;

        check_reset_state();
        if (!timed_out) run_directed_vectors();
        if (!timed_out) measure_latency();
        if (!timed_out) stream_random_sets();
        if (!timed_out) apply_back_pressure();

        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mean_tests.txt
# base step expected_mean, all hex
# sample i is the low 16 bits of base + i*step; mean is sum/128 truncated
0000 0000 0000
FFFF 0000 FFFF
0000 0001 003F
0001 0001 0040
0001 0000 0001
0000 0200 7F00
8000 0000 8000
FF00 0002 FF7F
FFC0 0001 7FFF
1234 0000 1234
0003 0005 0140
0000 0101 3FBF
0000 FFFF FDC0
7FFF 0000 7FFF
0080 0100 4000
FFFF FFFF FFBF
0000 8000 4000
0001 0002 0080
00FF 0000 00FF
0000 0003 00BE

// File: compile.f
mean_pkg.sv
pair_sum_level.sv
mean_output_buffer.sv
mean128.sv
tb_mean128.sv

// File: Makefile
# Verilator build and run of the mean pipeline testbench

SOURCES = mean_pkg.sv pair_sum_level.sv mean_output_buffer.sv mean128.sv tb_mean128.sv

.PHONY: all run clean

all: run

obj_dir/Vtb_mean128: compile.f $(SOURCES)
	verilator --binary --top-module tb_mean128 -f compile.f -o Vtb_mean128

run: obj_dir/Vtb_mean128
	./obj_dir/Vtb_mean128 > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@if grep -q "SIMULATION FAILED" sim.log; then \
		echo "run failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
